//--- hw/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 32;
    localparam int IMEM_ADDR_W = 8;
    localparam int DMEM_ADDR_W = 8;

    // Opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_SLTI  = 6'h0A;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2B;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_HALT  = 6'h3F;

    // R-type function codes
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_XOR = 6'h26;
    localparam logic [5:0] FN_NOR = 6'h27;
    localparam logic [5:0] FN_SLT = 6'h2A;
    localparam logic [5:0] FN_SLL = 6'h00;
    localparam logic [5:0] FN_SRL = 6'h02;
    localparam logic [5:0] FN_SRA = 6'h03;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_NOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef enum logic [1:0] {
        ALU_CLASS_ADD, ALU_CLASS_SUB, ALU_CLASS_SLT, ALU_CLASS_FUNCT
    } alu_class_e;

    // Encoding 2'b11 is never produced
    typedef enum logic [1:0] {
        FWD_REG, FWD_EXMEM, FWD_MEMWB
    } fwd_sel_e;

    typedef struct packed {
        logic       reg_write;
        logic       mem_to_reg;
        logic       mem_read;
        logic       mem_write;
        logic       branch;
        logic       branch_ne;
        logic       alu_src_imm;
        logic       dst_is_rd;
        logic       halt;
        alu_class_e alu_class;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc_plus4;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [XLEN-1:0]       pc_plus4;
        logic [XLEN-1:0]       rs_data;
        logic [XLEN-1:0]       rt_data;
        logic [XLEN-1:0]       imm_ext;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } id_ex_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_to_reg;
        logic                  mem_read;
        logic                  mem_write;
        logic                  branch;
        logic                  branch_ne;
        logic                  halt;
        logic [XLEN-1:0]       branch_target;
        logic                  zero;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] dst;
    } ex_mem_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_to_reg;
        logic                  halt;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       load_data;
        logic [REG_ADDR_W-1:0] dst;
    } mem_wb_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

`default_nettype wire

//--- hw/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage import mips_pkg::*; (
    input  wire                   i_clk,
    input  wire                   i_rst,
    input  wire                   i_step,
    input  wire                   i_stall,
    input  wire                   i_freeze,
    input  wire                   i_flush,
    input  wire                   i_take_branch,
    input  wire  [XLEN-1:0]       i_branch_target,
    input  wire                   i_imem_we,
    input  wire  [IMEM_ADDR_W-1:0] i_imem_addr,
    input  wire  [XLEN-1:0]       i_imem_data,
    output logic [XLEN-1:0]       o_pc,
    output if_id_t                o_if_id
);

    logic [XLEN-1:0] imem [2**IMEM_ADDR_W];
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] instr;
    logic            hold;

    assign pc_plus4 = o_pc + XLEN'(4);
    assign instr    = imem[o_pc[IMEM_ADDR_W+1:2]];
    assign hold     = i_stall || i_freeze;

    // Program load port, independent of step
    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_pc <= '0;
        end else if (i_step) begin
            if (i_take_branch) begin
                o_pc <= i_branch_target;
            end else if (!hold) begin
                o_pc <= pc_plus4;
            end
        end
    end

    // All-zero word decodes as a bubble
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_if_id <= '0;
        end else if (i_step) begin
            if (i_flush) begin
                o_if_id <= '0;
            end else if (!hold) begin
                o_if_id.pc_plus4 <= pc_plus4;
                o_if_id.instr    <= instr;
            end
        end
    end

    a_imem_addr_known: assert property (@(posedge i_clk)
        i_imem_we |-> !$isunknown(i_imem_addr));

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage import mips_pkg::*; (
    input  wire                    i_clk,
    input  wire                    i_rst,
    input  wire                    i_step,
    input  wire                    i_stall,
    input  wire                    i_flush,
    input  if_id_t                 i_if_id,
    input  wb_t                    i_wb,
    input  wire  [REG_ADDR_W-1:0]  i_dbg_reg_addr,
    output logic [XLEN-1:0]        o_dbg_reg_data,
    output id_ex_t                 o_id_ex,
    output logic [REG_ADDR_W-1:0]  o_decoded_rs,
    output logic [REG_ADDR_W-1:0]  o_decoded_rt,
    output logic                   o_decoded_halt
);

    logic [XLEN-1:0]       regs [NUM_REGS];
    logic [5:0]            opcode;
    logic [REG_ADDR_W-1:0] rd;
    ctrl_t                 ctrl;

    assign opcode       = i_if_id.instr[31:26];
    assign o_decoded_rs = i_if_id.instr[25:21];
    assign o_decoded_rt = i_if_id.instr[20:16];
    assign rd           = i_if_id.instr[15:11];

    // Write in WB is seen by a same-cycle read
    function automatic logic [XLEN-1:0] read_reg(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (i_wb.we && i_wb.addr == addr) begin
            return i_wb.data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_step && i_wb.we && i_wb.addr != '0) begin
            regs[i_wb.addr] <= i_wb.data;
        end
    end

    assign o_dbg_reg_data = regs[i_dbg_reg_addr];

    always_comb begin
        ctrl = '0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.dst_is_rd = 1'b1;
                ctrl.alu_class = ALU_CLASS_FUNCT;
            end
            OP_ADDI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_SLTI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_class   = ALU_CLASS_SLT;
            end
            OP_LW: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_SW: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = (opcode == OP_BNE);
                ctrl.alu_class = ALU_CLASS_SUB;
            end
            OP_HALT: ctrl.halt = 1'b1;
            default: ctrl = '0;
        endcase
        // Flushed or reset slot
        if (i_if_id.instr == '0) begin
            ctrl = '0;
        end
    end

    assign o_decoded_halt = ctrl.halt;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_id_ex <= '0;
        end else if (i_step) begin
            o_id_ex.ctrl     <= (i_stall || i_flush) ? ctrl_t'('0) : ctrl;
            o_id_ex.pc_plus4 <= i_if_id.pc_plus4;
            o_id_ex.rs_data  <= read_reg(o_decoded_rs);
            o_id_ex.rt_data  <= read_reg(o_decoded_rt);
            o_id_ex.imm_ext  <= {{(XLEN-16){i_if_id.instr[15]}}, i_if_id.instr[15:0]};
            o_id_ex.rs       <= o_decoded_rs;
            o_id_ex.rt       <= o_decoded_rt;
            o_id_ex.rd       <= rd;
            o_id_ex.shamt    <= i_if_id.instr[10:6];
            o_id_ex.funct    <= i_if_id.instr[5:0];
        end
    end

    a_r0_stays_zero: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_step && i_wb.we && i_wb.addr == '0) |=> regs[0] == '0);

endmodule

`default_nettype wire

//--- hw/hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit import mips_pkg::*; (
    input  wire                   i_id_ex_mem_read,
    input  wire  [REG_ADDR_W-1:0] i_id_ex_rt,
    input  wire  [REG_ADDR_W-1:0] i_decoded_rs,
    input  wire  [REG_ADDR_W-1:0] i_decoded_rt,
    input  wire                   i_decoded_halt,
    input  wire                   i_take_branch,
    output logic                  o_stall,
    output logic                  o_flush,
    output logic                  o_freeze
);

    logic load_use;

    // A load into r0 never needs a bubble
    assign load_use = i_id_ex_mem_read && i_id_ex_rt != '0
                   && (i_id_ex_rt == i_decoded_rs || i_id_ex_rt == i_decoded_rt);

    assign o_flush  = i_take_branch;
    // Wrong-path instructions, a halt among them, are dropped by the flush
    assign o_stall  = load_use && !i_take_branch;
    assign o_freeze = i_decoded_halt && !i_take_branch;

endmodule

`default_nettype wire

//--- hw/forwarding_unit.sv
`timescale 1ns/1ns
`default_nettype none

module forwarding_unit import mips_pkg::*; (
    input  wire                   i_ex_mem_reg_write,
    input  wire  [REG_ADDR_W-1:0] i_ex_mem_dst,
    input  wb_t                   i_wb,
    input  wire  [REG_ADDR_W-1:0] i_rs,
    input  wire  [REG_ADDR_W-1:0] i_rt,
    output fwd_sel_e              o_fwd_a,
    output fwd_sel_e              o_fwd_b
);

    // Youngest producer wins
    function automatic fwd_sel_e pick(input logic [REG_ADDR_W-1:0] src);
        if (src == '0) begin
            return FWD_REG;
        end
        if (i_ex_mem_reg_write && i_ex_mem_dst == src) begin
            return FWD_EXMEM;
        end
        if (i_wb.we && i_wb.addr == src) begin
            return FWD_MEMWB;
        end
        return FWD_REG;
    endfunction

    assign o_fwd_a = pick(i_rs);
    assign o_fwd_b = pick(i_rt);

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage import mips_pkg::*; (
    input  wire      i_clk,
    input  wire      i_rst,
    input  wire      i_step,
    input  wire      i_flush,
    input  id_ex_t   i_id_ex,
    input  fwd_sel_e i_fwd_a,
    input  fwd_sel_e i_fwd_b,
    input  wb_t      i_wb,
    output ex_mem_t  o_ex_mem
);

    alu_op_e         alu_op;
    logic            is_shift;
    logic [XLEN-1:0] rs_val;
    logic [XLEN-1:0] rt_val;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic            keep;

    function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                input logic [XLEN-1:0] reg_val);
        case (sel)
            FWD_EXMEM: return o_ex_mem.alu_result;
            FWD_MEMWB: return i_wb.data;
            default:   return reg_val;
        endcase
    endfunction

    always_comb begin
        case (i_id_ex.ctrl.alu_class)
            ALU_CLASS_SUB: alu_op = ALU_SUB;
            ALU_CLASS_SLT: alu_op = ALU_SLT;
            ALU_CLASS_FUNCT: begin
                case (i_id_ex.funct)
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    default: alu_op = ALU_ADD;
                endcase
            end
            default: alu_op = ALU_ADD;
        endcase
    end

    assign is_shift = alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA};
    assign rs_val   = fwd_mux(i_fwd_a, i_id_ex.rs_data);
    assign rt_val   = fwd_mux(i_fwd_b, i_id_ex.rt_data);
    // Shift amount comes from the instruction, value from rt
    assign op_a     = is_shift ? XLEN'(i_id_ex.shamt) : rs_val;
    assign op_b     = i_id_ex.ctrl.alu_src_imm ? i_id_ex.imm_ext : rt_val;

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_NOR: alu_result = ~(op_a | op_b);
            ALU_SLT: alu_result = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLL: alu_result = op_b << op_a[4:0];
            ALU_SRL: alu_result = op_b >> op_a[4:0];
            ALU_SRA: alu_result = $signed(op_b) >>> op_a[4:0];
            default: alu_result = op_a + op_b;
        endcase
    end

    assign keep = !i_flush;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ex_mem <= '0;
        end else if (i_step) begin
            o_ex_mem.reg_write     <= i_id_ex.ctrl.reg_write && keep;
            o_ex_mem.mem_to_reg    <= i_id_ex.ctrl.mem_to_reg && keep;
            o_ex_mem.mem_read      <= i_id_ex.ctrl.mem_read && keep;
            o_ex_mem.mem_write     <= i_id_ex.ctrl.mem_write && keep;
            o_ex_mem.branch        <= i_id_ex.ctrl.branch && keep;
            o_ex_mem.branch_ne     <= i_id_ex.ctrl.branch_ne && keep;
            o_ex_mem.halt          <= i_id_ex.ctrl.halt && keep;
            o_ex_mem.branch_target <= i_id_ex.pc_plus4 + {i_id_ex.imm_ext[XLEN-3:0], 2'b00};
            o_ex_mem.zero          <= (alu_result == '0);
            o_ex_mem.alu_result    <= alu_result;
            o_ex_mem.store_data    <= rt_val;
            o_ex_mem.dst           <= i_id_ex.ctrl.dst_is_rd ? i_id_ex.rd : i_id_ex.rt;
        end
    end

    a_fwd_encoding: assert property (@(posedge i_clk) disable iff (i_rst)
        i_step |-> (2'(i_fwd_a) != 2'b11 && 2'(i_fwd_b) != 2'b11));

endmodule

`default_nettype wire

//--- hw/memory_stage.sv
`timescale 1ns/1ns
`default_nettype none

module memory_stage import mips_pkg::*; (
    input  wire             i_clk,
    input  wire             i_rst,
    input  wire             i_step,
    input  ex_mem_t         i_ex_mem,
    output logic            o_take_branch,
    output logic [XLEN-1:0] o_branch_target,
    output wb_t             o_wb,
    output logic            o_halted
);

    logic [XLEN-1:0]        dmem [2**DMEM_ADDR_W];
    logic [DMEM_ADDR_W-1:0] word_addr;
    mem_wb_t                mem_wb_q;

    assign o_take_branch   = i_ex_mem.branch && (i_ex_mem.branch_ne ^ i_ex_mem.zero);
    assign o_branch_target = i_ex_mem.branch_target;

    // Word addressed
    assign word_addr = i_ex_mem.alu_result[DMEM_ADDR_W+1:2];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < 2**DMEM_ADDR_W; i++) begin
                dmem[i] <= '0;
            end
        end else if (i_step && i_ex_mem.mem_write) begin
            dmem[word_addr] <= i_ex_mem.store_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            mem_wb_q <= '0;
        end else if (i_step) begin
            mem_wb_q.reg_write  <= i_ex_mem.reg_write;
            mem_wb_q.mem_to_reg <= i_ex_mem.mem_to_reg;
            mem_wb_q.halt       <= i_ex_mem.halt;
            mem_wb_q.alu_result <= i_ex_mem.alu_result;
            mem_wb_q.load_data  <= dmem[word_addr];
            mem_wb_q.dst        <= i_ex_mem.dst;
        end
    end

    assign o_wb.we   = mem_wb_q.reg_write;
    assign o_wb.addr = mem_wb_q.dst;
    assign o_wb.data = mem_wb_q.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_result;

    // Sticky until the next reset
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_halted <= 1'b0;
        end else if (i_step && mem_wb_q.halt) begin
            o_halted <= 1'b1;
        end
    end

    a_rd_wr_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_ex_mem.mem_read && i_ex_mem.mem_write));

endmodule

`default_nettype wire

//--- hw/mips_top.sv
`timescale 1ns/1ns
`default_nettype none

module mips_top import mips_pkg::*; (
    input  wire                    i_clk,
    input  wire                    i_rst,
    input  wire                    i_step,
    input  wire                    i_imem_we,
    input  wire  [IMEM_ADDR_W-1:0] i_imem_addr,
    input  wire  [XLEN-1:0]        i_imem_data,
    input  wire  [REG_ADDR_W-1:0]  i_dbg_reg_addr,
    output logic [XLEN-1:0]        o_dbg_reg_data,
    output logic [XLEN-1:0]        o_pc,
    output logic                   o_halted
);

    if_id_t                if_id;
    id_ex_t                id_ex;
    ex_mem_t               ex_mem;
    wb_t                   wb;
    logic                  take_branch;
    logic [XLEN-1:0]       branch_target;
    logic                  stall;
    logic                  flush;
    logic                  freeze;
    logic [REG_ADDR_W-1:0] decoded_rs;
    logic [REG_ADDR_W-1:0] decoded_rt;
    logic                  decoded_halt;
    fwd_sel_e              fwd_a;
    fwd_sel_e              fwd_b;

    fetch_stage u_fetch (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_step          (i_step),
        .i_stall         (stall),
        .i_freeze        (freeze),
        .i_flush         (flush),
        .i_take_branch   (take_branch),
        .i_branch_target (branch_target),
        .i_imem_we       (i_imem_we),
        .i_imem_addr     (i_imem_addr),
        .i_imem_data     (i_imem_data),
        .o_pc            (o_pc),
        .o_if_id         (if_id)
    );

    decode_stage u_decode (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_step         (i_step),
        .i_stall        (stall),
        .i_flush        (flush),
        .i_if_id        (if_id),
        .i_wb           (wb),
        .i_dbg_reg_addr (i_dbg_reg_addr),
        .o_dbg_reg_data (o_dbg_reg_data),
        .o_id_ex        (id_ex),
        .o_decoded_rs   (decoded_rs),
        .o_decoded_rt   (decoded_rt),
        .o_decoded_halt (decoded_halt)
    );

    hazard_unit u_hazard (
        .i_id_ex_mem_read (id_ex.ctrl.mem_read),
        .i_id_ex_rt       (id_ex.rt),
        .i_decoded_rs     (decoded_rs),
        .i_decoded_rt     (decoded_rt),
        .i_decoded_halt   (decoded_halt),
        .i_take_branch    (take_branch),
        .o_stall          (stall),
        .o_flush          (flush),
        .o_freeze         (freeze)
    );

    forwarding_unit u_fwd (
        .i_ex_mem_reg_write (ex_mem.reg_write),
        .i_ex_mem_dst       (ex_mem.dst),
        .i_wb               (wb),
        .i_rs               (id_ex.rs),
        .i_rt               (id_ex.rt),
        .o_fwd_a            (fwd_a),
        .o_fwd_b            (fwd_b)
    );

    execute_stage u_execute (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_step   (i_step),
        .i_flush  (flush),
        .i_id_ex  (id_ex),
        .i_fwd_a  (fwd_a),
        .i_fwd_b  (fwd_b),
        .i_wb     (wb),
        .o_ex_mem (ex_mem)
    );

    memory_stage u_memory (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_step          (i_step),
        .i_ex_mem        (ex_mem),
        .o_take_branch   (take_branch),
        .o_branch_target (branch_target),
        .o_wb            (wb),
        .o_halted        (o_halted)
    );

endmodule

`default_nettype wire

//--- verif/tb_isa.svh
`ifndef TB_ISA_SVH
`define TB_ISA_SVH

// Fields in MIPS order
function automatic logic [31:0] r_type(input logic [5:0] fn, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [4:0] rd,
                                       input logic [4:0] sh);
    return {OP_RTYPE, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] halt_word();
    return {OP_HALT, 26'd0};
endfunction

task automatic emit(input logic [31:0] word);
    prog.push_back(word);
endtask

task automatic wait_cycle();
    @(posedge clk);
    #1;
endtask

// Pipeline stays frozen while the program goes in
task automatic load_program();
    step = 1'b0;
    for (int i = 0; i < prog.size(); i++) begin
        imem_we   = 1'b1;
        imem_addr = IMEM_ADDR_W'(i);
        imem_data = prog[i];
        wait_cycle();
    end
    imem_we = 1'b0;
    rst     = 1'b1;
    repeat (3) wait_cycle();
    rst = 1'b0;
endtask

task automatic run_until_halt();
    step = 1'b1;
    while (!halted) begin
        wait_cycle();
    end
endtask

task automatic read_reg(input logic [4:0] idx, output logic [31:0] value);
    dbg_reg_addr = idx;
    wait_cycle();
    value = dbg_reg_data;
endtask

`endif

//--- verif/tb_mips_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mips_top import mips_pkg::*; ();

    localparam int NUM_TESTS      = 6;
    localparam int MAX_PROG_LEN   = 48;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (MAX_PROG_LEN * 3 + 20);
    localparam int RAND_SEED      = 50422;

    logic                   clk;
    logic                   rst;
    logic                   step;
    logic                   imem_we;
    logic [IMEM_ADDR_W-1:0] imem_addr;
    logic [XLEN-1:0]        imem_data;
    logic [REG_ADDR_W-1:0]  dbg_reg_addr;
    logic [XLEN-1:0]        dbg_reg_data;
    logic [XLEN-1:0]        pc;
    logic                   halted;
    logic [XLEN-1:0]        prog [$];
    string                  test_name;
    int                     cycle_count = 0;

    mips_top dut0 (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_step         (step),
        .i_imem_we      (imem_we),
        .i_imem_addr    (imem_addr),
        .i_imem_data    (imem_data),
        .i_dbg_reg_addr (dbg_reg_addr),
        .o_dbg_reg_data (dbg_reg_data),
        .o_pc           (pc),
        .o_halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT never reached halt", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    `include "tb_isa.svh"

    task automatic compare(input string what, input logic [XLEN-1:0] expected,
                           input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s (%s): expected %h, actual %h",
                     test_name, what, expected, actual);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic expect_reg(input logic [4:0] idx, input logic [XLEN-1:0] expected);
        logic [XLEN-1:0] value;
        read_reg(idx, value);
        compare($sformatf("r%0d", idx), expected, value);
    endtask

    // Reference semantics of the R-type ops
    function automatic logic [XLEN-1:0] alu_ref(input logic [5:0] fn, input logic [31:0] a,
                                                input logic [31:0] b, input logic [4:0] sh);
        case (fn)
            FN_ADD:  return a + b;
            FN_SUB:  return a - b;
            FN_AND:  return a & b;
            FN_OR:   return a | b;
            FN_XOR:  return a ^ b;
            FN_NOR:  return ~(a | b);
            FN_SLT:  return {31'd0, $signed(a) < $signed(b)};
            FN_SLL:  return b << sh;
            FN_SRL:  return b >> sh;
            FN_SRA:  return $signed(b) >>> sh;
            default: return '0;
        endcase
    endfunction

    task automatic arith_chain();
        test_name = "arith_chain";
        prog.delete();
        emit(i_type(OP_ADDI, 5'd0, 5'd1, 16'hFFFB));
        emit(r_type(FN_ADD, 5'd1, 5'd1, 5'd2, 5'd0));
        emit(r_type(FN_SUB, 5'd2, 5'd1, 5'd3, 5'd0));
        emit(r_type(FN_SLT, 5'd2, 5'd3, 5'd4, 5'd0));
        emit(r_type(FN_NOR, 5'd4, 5'd0, 5'd5, 5'd0));
        emit(r_type(FN_SLL, 5'd0, 5'd5, 5'd6, 5'd4));
        emit(r_type(FN_SRA, 5'd0, 5'd6, 5'd7, 5'd2));
        emit(halt_word());
        load_program();
        run_until_halt();
        expect_reg(5'd1, 32'hFFFF_FFFB);
        expect_reg(5'd2, 32'hFFFF_FFF6);
        expect_reg(5'd3, 32'hFFFF_FFFB);
        expect_reg(5'd4, 32'h0000_0001);
        expect_reg(5'd5, 32'hFFFF_FFFE);
        expect_reg(5'd6, 32'hFFFF_FFE0);
        expect_reg(5'd7, 32'hFFFF_FFF8);
    endtask

    task automatic load_use_stall();
        test_name = "load_use_stall";
        prog.delete();
        emit(i_type(OP_ADDI, 5'd0, 5'd1, 16'd100));
        emit(i_type(OP_SW, 5'd0, 5'd1, 16'd8));
        emit(i_type(OP_LW, 5'd0, 5'd2, 16'd8));
        emit(i_type(OP_ADDI, 5'd2, 5'd3, 16'd5));
        emit(r_type(FN_ADD, 5'd3, 5'd2, 5'd4, 5'd0));
        emit(halt_word());
        load_program();
        run_until_halt();
        expect_reg(5'd2, 32'd100);
        expect_reg(5'd3, 32'd105);
        expect_reg(5'd4, 32'd205);
    endtask

    task automatic branch_flush();
        test_name = "branch_flush";
        prog.delete();
        emit(i_type(OP_ADDI, 5'd0, 5'd1, 16'd3));
        emit(i_type(OP_ADDI, 5'd0, 5'd2, 16'd3));
        // Taken, skips the three markers below
        emit(i_type(OP_BEQ, 5'd1, 5'd2, 16'd3));
        for (int r = 10; r < 13; r++) begin
            emit(i_type(OP_ADDI, 5'd0, 5'(r), 16'd1));
        end
        emit(i_type(OP_BNE, 5'd1, 5'd2, 16'd3));
        for (int r = 13; r < 16; r++) begin
            emit(i_type(OP_ADDI, 5'd0, 5'(r), 16'd2));
        end
        emit(halt_word());
        load_program();
        run_until_halt();
        for (int r = 10; r < 13; r++) begin
            expect_reg(5'(r), 32'd0);
        end
        for (int r = 13; r < 16; r++) begin
            expect_reg(5'(r), 32'd2);
        end
    endtask

    task automatic step_freeze();
        test_name = "step_freeze";
        prog.delete();
        emit(i_type(OP_ADDI, 5'd0, 5'd1, 16'd42));
        emit(i_type(OP_ADDI, 5'd1, 5'd2, 16'd1));
        emit(halt_word());
        load_program();
        repeat (10) begin
            wait_cycle();
            compare("o_pc with step low", 32'd0, pc);
            compare("o_halted with step low", 32'd0, 32'(halted));
        end
        run_until_halt();
        expect_reg(5'd1, 32'd42);
        expect_reg(5'd2, 32'd43);
    endtask

    task automatic random_alu();
        logic [5:0]      fn_list [10];
        logic [XLEN-1:0] model [NUM_REGS];
        logic [15:0]     imm;
        logic [5:0]      fn;
        logic [4:0]      rs;
        logic [4:0]      rt;
        logic [4:0]      rd;
        logic [4:0]      sh;
        test_name = "random_alu";
        fn_list = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR,
                    FN_NOR, FN_SLT, FN_SLL, FN_SRL, FN_SRA};
        prog.delete();
        for (int r = 0; r < NUM_REGS; r++) begin
            model[r] = '0;
        end
        for (int r = 1; r <= 20; r++) begin
            imm = 16'($urandom());
            emit(i_type(OP_ADDI, 5'd0, 5'(r), imm));
            model[r] = {{16{imm[15]}}, imm};
        end
        for (int k = 0; k < 24; k++) begin
            fn = fn_list[$urandom_range(9)];
            rs = 5'($urandom_range(31));
            rt = 5'($urandom_range(31));
            rd = 5'($urandom_range(31, 1));
            sh = 5'($urandom());
            emit(r_type(fn, rs, rt, rd, sh));
            model[rd] = alu_ref(fn, model[rs], model[rt], sh);
        end
        emit(halt_word());
        load_program();
        run_until_halt();
        for (int r = 0; r < NUM_REGS; r++) begin
            expect_reg(5'(r), model[r]);
        end
    endtask

    task automatic halt_freeze();
        logic [XLEN-1:0] pc_at_halt;
        test_name = "halt_freeze";
        prog.delete();
        emit(i_type(OP_ADDI, 5'd0, 5'd1, 16'd9));
        emit(halt_word());
        emit(i_type(OP_ADDI, 5'd0, 5'd2, 16'd77));
        load_program();
        run_until_halt();
        pc_at_halt = pc;
        // Fetch stops one word past the halt
        compare("o_pc at halt", 32'd8, pc_at_halt);
        repeat (10) begin
            wait_cycle();
            compare("o_pc after halt", pc_at_halt, pc);
            compare("o_halted after halt", 32'd1, 32'(halted));
        end
        expect_reg(5'd1, 32'd9);
        expect_reg(5'd2, 32'd0);
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        rst          = 1'b1;
        step         = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_data    = '0;
        dbg_reg_addr = '0;
        repeat (3) wait_cycle();
        rst = 1'b0;
        arith_chain();
        load_use_stall();
        branch_flush();
        step_freeze();
        random_alu();
        halt_freeze();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+verif
hw/mips_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/hazard_unit.sv
hw/forwarding_unit.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/mips_top.sv
verif/tb_mips_top.sv

//--- Bender.yml
package:
  name: mips_pipeline

sources:
  - hw/mips_pkg.sv
  - hw/fetch_stage.sv
  - hw/decode_stage.sv
  - hw/hazard_unit.sv
  - hw/forwarding_unit.sv
  - hw/execute_stage.sv
  - hw/memory_stage.sv
  - hw/mips_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_mips_top.sv
